// ==== common/nlc_params.svh ====
`ifndef NLC_PARAMS_SVH
`define NLC_PARAMS_SVH

// Channel count and sample width at the ADC side
`define NLC_NUM_CH 4
`define NLC_SAMPLE_W 21

// Fixed-point format of constants and arithmetic
`define NLC_WORD_W 32
`define NLC_FRAC 16

// neg_mean, recip_stdev, then coeff_5 down to coeff_0
`define NLC_WORDS_PER_CH 8
`define NLC_ORDER 5

`endif

// ==== common/nlc_pkg.sv ====
`include "nlc_params.svh"

package nlc_pkg;

	typedef logic signed [`NLC_SAMPLE_W-1:0] sample_t;
	typedef logic signed [`NLC_WORD_W-1:0] word_t;
	typedef logic [$clog2(`NLC_NUM_CH)-1:0] ch_idx_t;

	// channel * 8 + slot
	// slots: 0 neg_mean, 1 recip_stdev, 2..7 coeff_5..coeff_0
	typedef logic [$clog2(`NLC_NUM_CH*`NLC_WORDS_PER_CH)-1:0] cfg_addr_t;

	typedef enum logic [2:0] {
		OP_NONE,
		OP_CENTER,
		OP_SCALE,
		OP_LOAD,
		OP_MAC
	} dp_op_t;

	typedef enum logic {S_IDLE, S_RUN} seq_state_t;

endpackage

// ==== verilog/sample_capture.sv ====
`timescale 1ns/1ps
`include "nlc_params.svh"

module sample_capture (
	input logic clk,
	input logic rst,
	input logic capture,
	input logic [`NLC_NUM_CH*`NLC_SAMPLE_W-1:0] x_adc,
	input nlc_pkg::ch_idx_t ch,
	output nlc_pkg::sample_t sample
);
	import nlc_pkg::*;

	sample_t samples [`NLC_NUM_CH];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `NLC_NUM_CH; i++) begin
				samples[i] <= '0;
			end
		end else if (capture) begin
			// Whole frame at once, channel 0 in the low bits
			for (int i = 0; i < `NLC_NUM_CH; i++) begin
				samples[i] <= x_adc[i*`NLC_SAMPLE_W +: `NLC_SAMPLE_W];
			end
		end
	end

	assign sample = samples[ch];

endmodule

// ==== verilog/coeff_table.sv ====
`timescale 1ns/1ps
`include "nlc_params.svh"

module coeff_table (
	input logic clk,
	input logic rst,
	input logic cfg_we,
	input nlc_pkg::cfg_addr_t cfg_addr,
	input nlc_pkg::word_t cfg_data,
	input nlc_pkg::ch_idx_t ch,
	input logic [$clog2(`NLC_WORDS_PER_CH)-1:0] word,
	output nlc_pkg::word_t operand
);
	import nlc_pkg::*;

	localparam int DEPTH = `NLC_NUM_CH * `NLC_WORDS_PER_CH;

	word_t regs [DEPTH];
	cfg_addr_t rd_addr;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				regs[i] <= '0;
			end
		end else if (cfg_we) begin
			regs[cfg_addr] <= cfg_data;
		end
	end

	// Channel in the upper bits, slot below
	assign rd_addr = {ch, word};
	assign operand = regs[rd_addr];

endmodule

// ==== nlc_engine/nlc_sequencer.sv ====
`timescale 1ns/1ps
`include "nlc_params.svh"

module nlc_sequencer (
	input logic clk,
	input logic rst,
	input logic srdyi,
	output logic capture,
	output logic busy,
	output nlc_pkg::ch_idx_t ch,
	output logic [$clog2(`NLC_WORDS_PER_CH)-1:0] word,
	output nlc_pkg::dp_op_t op,
	output logic res_we,
	output nlc_pkg::ch_idx_t res_ch,
	output logic frame_done
);
	import nlc_pkg::*;

	// center, scale, load, then one MAC per remaining coefficient
	localparam int LAST_STEP = `NLC_ORDER + 2;
	localparam int LAST_CH = `NLC_NUM_CH - 1;

	seq_state_t state;
	logic [$clog2(`NLC_WORDS_PER_CH)-1:0] step;
	logic step_last;
	logic ch_last;

	assign capture = (state == S_IDLE) && srdyi;
	assign busy = (state == S_RUN);
	assign step_last = (step == LAST_STEP);
	assign ch_last = (ch == LAST_CH);
	assign word = step; // step number doubles as table slot

	always_comb begin
		op = OP_NONE;
		if (busy && !frame_done) begin // idle during the tail cycle
			case (step)
				0: op = OP_CENTER;
				1: op = OP_SCALE;
				2: op = OP_LOAD;
				default: op = OP_MAC;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			ch <= '0;
			step <= '0;
			res_we <= 1'b0;
			res_ch <= '0;
			frame_done <= 1'b0;
		end else begin
			res_we <= 1'b0;
			frame_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (srdyi) begin
						state <= S_RUN;
						ch <= '0;
						step <= '0;
					end
				end
				S_RUN: begin
					if (frame_done) begin
						state <= S_IDLE;
					end else if (step_last) begin
						// acc is final after this edge, write it on the next
						step <= '0;
						res_we <= 1'b1;
						res_ch <= ch;
						if (ch_last) begin
							frame_done <= 1'b1;
							ch <= '0;
						end else begin
							ch <= ch + 1'b1;
						end
					end else begin
						step <= step + 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== nlc_engine/horner_datapath.sv ====
`timescale 1ns/1ps
`include "nlc_params.svh"

module horner_datapath (
	input logic clk,
	input logic rst,
	input nlc_pkg::dp_op_t op,
	input nlc_pkg::sample_t sample,
	input nlc_pkg::word_t operand,
	output nlc_pkg::word_t acc
);
	import nlc_pkg::*;

	word_t z;
	word_t sample_ext;
	word_t mul_a;
	word_t mul_b;
	word_t mul_q;
	logic signed [2*`NLC_WORD_W-1:0] prod;
	logic signed [2*`NLC_WORD_W-1:0] prod_sh;

	assign sample_ext = {{(`NLC_WORD_W-`NLC_SAMPLE_W){sample[`NLC_SAMPLE_W-1]}}, sample};

	// One multiplier, shared by the scale step and the Horner MAC
	assign mul_a = (op == OP_MAC) ? acc : z;
	assign mul_b = (op == OP_MAC) ? z : operand;
	assign prod = mul_a * mul_b;
	assign prod_sh = prod >>> `NLC_FRAC;
	assign mul_q = prod_sh[`NLC_WORD_W-1:0]; // wraps like the model

	always_ff @(posedge clk) begin
		if (rst) begin
			z <= '0;
			acc <= '0;
		end else begin
			case (op)
				OP_CENTER: z <= sample_ext + operand;
				OP_SCALE: z <= mul_q;
				OP_LOAD: acc <= operand; // coeff_5
				OP_MAC: acc <= mul_q + operand;
				default: ;
			endcase
		end
	end

endmodule

// ==== verilog/result_store.sv ====
`timescale 1ns/1ps
`include "nlc_params.svh"

module result_store (
	input logic clk,
	input logic rst,
	input logic res_we,
	input nlc_pkg::ch_idx_t res_ch,
	input nlc_pkg::word_t acc,
	input logic frame_done,
	output logic [`NLC_NUM_CH*`NLC_SAMPLE_W-1:0] x_lin,
	output logic srdyo
);
	import nlc_pkg::*;

	localparam word_t SAT_MAX = word_t'((1 << (`NLC_SAMPLE_W-1)) - 1);
	localparam word_t SAT_MIN = -SAT_MAX - 1;

	sample_t sat;

	// Clamp to the signed sample range
	always_comb begin
		if (acc > SAT_MAX) begin
			sat = SAT_MAX[`NLC_SAMPLE_W-1:0];
		end else if (acc < SAT_MIN) begin
			sat = SAT_MIN[`NLC_SAMPLE_W-1:0];
		end else begin
			sat = acc[`NLC_SAMPLE_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			x_lin <= '0;
			srdyo <= 1'b0;
		end else begin
			srdyo <= frame_done; // same edge as the last write
			if (res_we) begin
				x_lin[res_ch*`NLC_SAMPLE_W +: `NLC_SAMPLE_W] <= sat;
			end
		end
	end

endmodule

// ==== verilog/nlc_controller.sv ====
`timescale 1ns/1ps
`include "nlc_params.svh"

module nlc_controller (
	input logic clk,
	input logic rst,
	input logic srdyi,
	input logic [`NLC_NUM_CH*`NLC_SAMPLE_W-1:0] x_adc,
	input logic cfg_we,
	input nlc_pkg::cfg_addr_t cfg_addr,
	input nlc_pkg::word_t cfg_data,
	output logic [`NLC_NUM_CH*`NLC_SAMPLE_W-1:0] x_lin,
	output logic srdyo,
	output logic busy
);
	import nlc_pkg::*;

	logic capture;
	ch_idx_t ch;
	logic [$clog2(`NLC_WORDS_PER_CH)-1:0] word;
	dp_op_t op;
	logic res_we;
	ch_idx_t res_ch;
	logic frame_done;
	sample_t sample;
	word_t operand;
	word_t acc;

	// Input side
	sample_capture i_sample_capture (
		.clk (clk),
		.rst (rst),
		.capture (capture),
		.x_adc (x_adc),
		.ch (ch),
		.sample (sample)
	);

	coeff_table i_coeff_table (
		.clk (clk),
		.rst (rst),
		.cfg_we (cfg_we),
		.cfg_addr (cfg_addr),
		.cfg_data (cfg_data),
		.ch (ch),
		.word (word),
		.operand (operand)
	);

	nlc_sequencer i_nlc_sequencer (
		.clk (clk),
		.rst (rst),
		.srdyi (srdyi),
		.capture (capture),
		.busy (busy),
		.ch (ch),
		.word (word),
		.op (op),
		.res_we (res_we),
		.res_ch (res_ch),
		.frame_done (frame_done)
	);

	horner_datapath i_horner_datapath (
		.clk (clk),
		.rst (rst),
		.op (op),
		.sample (sample),
		.operand (operand),
		.acc (acc)
	);

	// Output side
	result_store i_result_store (
		.clk (clk),
		.rst (rst),
		.res_we (res_we),
		.res_ch (res_ch),
		.acc (acc),
		.frame_done (frame_done),
		.x_lin (x_lin),
		.srdyo (srdyo)
	);

endmodule

// ==== verif/nlc_model.svh ====
`ifndef NLC_MODEL_SVH
`define NLC_MODEL_SVH

`include "nlc_params.svh"

// 32-bit xorshift, state never zero
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// Q16 product, shifted back and wrapped to one word
function automatic logic signed [`NLC_WORD_W-1:0] fixed_mul(
	input logic signed [`NLC_WORD_W-1:0] a,
	input logic signed [`NLC_WORD_W-1:0] b
);
	longint p;
	p = longint'(a) * longint'(b);
	p = p >>> `NLC_FRAC;
	return p[`NLC_WORD_W-1:0];
endfunction

// Center, scale, Horner from coeff_5 down to coeff_0, then clamp
function automatic logic signed [`NLC_SAMPLE_W-1:0] correct_sample(
	input logic signed [`NLC_SAMPLE_W-1:0] sample,
	input logic [`NLC_WORDS_PER_CH*`NLC_WORD_W-1:0] words
);
	logic signed [`NLC_WORD_W-1:0] w [`NLC_WORDS_PER_CH];
	logic signed [`NLC_WORD_W-1:0] z;
	logic signed [`NLC_WORD_W-1:0] acc;
	int lim_hi;
	int lim_lo;
	lim_hi = (1 <<< (`NLC_SAMPLE_W - 1)) - 1;
	lim_lo = -lim_hi - 1;
	for (int k = 0; k < `NLC_WORDS_PER_CH; k++) begin
		w[k] = words[k*`NLC_WORD_W +: `NLC_WORD_W];
	end
	z = sample; // sign extension
	z = z + w[0];
	z = fixed_mul(z, w[1]);
	acc = w[2];
	for (int k = 3; k < `NLC_WORDS_PER_CH; k++) begin
		acc = fixed_mul(acc, z) + w[k];
	end
	if (acc > lim_hi) begin
		acc = lim_hi;
	end else if (acc < lim_lo) begin
		acc = lim_lo;
	end
	return acc[`NLC_SAMPLE_W-1:0];
endfunction

`endif

// ==== verif/tb_nlc_controller.sv ====
`timescale 1ns/1ps
`include "nlc_params.svh"
`include "nlc_model.svh"

module tb_nlc_controller;
	import nlc_pkg::*;

	localparam int ADC_W = `NLC_NUM_CH * `NLC_SAMPLE_W;
	localparam int DEPTH = `NLC_NUM_CH * `NLC_WORDS_PER_CH;
	localparam int FRAME_EDGES = `NLC_NUM_CH * `NLC_WORDS_PER_CH + 1;
	localparam int TIMEOUT_CYCLES = 12 * 40 + 200; // 12 frames plus loading and reset

	logic clk;
	logic rst;
	logic srdyi;
	logic [ADC_W-1:0] x_adc;
	logic cfg_we;
	cfg_addr_t cfg_addr;
	word_t cfg_data;
	logic [ADC_W-1:0] x_lin;
	logic srdyo;
	logic busy;

	word_t shadow [DEPTH]; // copy of the coefficient table
	logic [31:0] rng_state;
	int cycle_count;
	int error_count;
	int check_count;

	nlc_controller i_nlc_controller (
		.clk (clk),
		.rst (rst),
		.srdyi (srdyi),
		.x_adc (x_adc),
		.cfg_we (cfg_we),
		.cfg_addr (cfg_addr),
		.cfg_data (cfg_data),
		.x_lin (x_lin),
		.srdyo (srdyo),
		.busy (busy)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: test still running after %0d cycles", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		assert (actual === expected) else begin
			$display("Fail %s expected 0x%h got 0x%h", name, expected, actual);
			error_count++;
		end
	endtask

	// Signed value in -2^(bits-1) .. 2^(bits-1)-1
	function automatic logic signed [31:0] small_random(input int bits);
		logic signed [31:0] v;
		rng_state = xorshift32(rng_state);
		v = rng_state;
		return v >>> (32 - bits);
	endfunction

	function automatic logic [ADC_W-1:0] random_adc(input int bits);
		logic [ADC_W-1:0] a;
		logic signed [31:0] r;
		for (int ch = 0; ch < `NLC_NUM_CH; ch++) begin
			r = small_random(bits);
			a[ch*`NLC_SAMPLE_W +: `NLC_SAMPLE_W] = r[`NLC_SAMPLE_W-1:0];
		end
		return a;
	endfunction

	task automatic apply_reset();
		rst = 1'b1;
		srdyi = 1'b0;
		cfg_we = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			shadow[i] = '0;
		end
	endtask

	task automatic write_word(input int addr, input word_t data);
		@(negedge clk);
		cfg_we = 1'b1;
		cfg_addr = cfg_addr_t'(addr);
		cfg_data = data;
		shadow[addr] = data;
	endtask

	// recip_stdev and coeff_1 at 1.0 on a cleared table
	task automatic load_identity();
		for (int ch = 0; ch < `NLC_NUM_CH; ch++) begin
			write_word(ch * `NLC_WORDS_PER_CH + 1, 32'h0001_0000);
			write_word(ch * `NLC_WORDS_PER_CH + 6, 32'h0001_0000);
		end
	endtask

	task automatic load_random_channel(input int ch);
		write_word(ch * `NLC_WORDS_PER_CH, small_random(14));
		write_word(ch * `NLC_WORDS_PER_CH + 1, 32'h0001_0000 + small_random(15));
		for (int k = 2; k < `NLC_WORDS_PER_CH; k++) begin
			write_word(ch * `NLC_WORDS_PER_CH + k, small_random(17)); // within +-1.0
		end
	endtask

	task automatic check_results(input logic [ADC_W-1:0] expected);
		for (int ch = 0; ch < `NLC_NUM_CH; ch++) begin
			check_value($sformatf("x_lin[%0d]", ch),
				32'(expected[ch*`NLC_SAMPLE_W +: `NLC_SAMPLE_W]),
				32'(x_lin[ch*`NLC_SAMPLE_W +: `NLC_SAMPLE_W]));
		end
	endtask

	// retrigger_at < 0 means no srdyi during the frame
	task automatic run_frame(input logic [ADC_W-1:0] adc, input int retrigger_at,
			input logic [ADC_W-1:0] adc_alt);
		int n;
		@(negedge clk);
		check_value("busy", 0, busy);
		cfg_we = 1'b0;
		srdyi = 1'b1;
		x_adc = adc;
		@(negedge clk); // E0 just passed
		check_value("busy", 1, busy);
		n = 0;
		while (srdyo !== 1'b1 && n < FRAME_EDGES + 8) begin
			srdyi = (retrigger_at >= 0) && (n == retrigger_at || n == FRAME_EDGES - 1);
			if (n == retrigger_at) begin
				x_adc = adc_alt;
			end
			@(negedge clk);
			n++;
			if (srdyo !== 1'b1) begin
				check_value("busy", 1, busy);
			end
		end
		srdyi = 1'b0;
		check_count++;
		assert (srdyo === 1'b1) else begin
			$display("srdyo did not arrive within %0d cycles after srdyi was taken", n);
			error_count++;
		end
		check_value("srdyo_delay", FRAME_EDGES, n);
		check_value("busy", 0, busy);
		@(negedge clk);
		check_value("srdyo", 0, srdyo); // one cycle only
	endtask

	initial begin
		logic [ADC_W-1:0] adc;
		logic [ADC_W-1:0] alt;
		logic [ADC_W-1:0] expected;
		logic [`NLC_WORDS_PER_CH*`NLC_WORD_W-1:0] words;
		clk = 1'b0;
		rst = 1'b1;
		srdyi = 1'b0;
		x_adc = '0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_data = '0;
		rng_state = 32'd63;
		cycle_count = 0;
		error_count = 0;
		check_count = 0;
		apply_reset();

		check_value("srdyo", 0, srdyo);
		check_value("busy", 0, busy);
		check_results('0);

		load_identity();
		adc = random_adc(`NLC_SAMPLE_W);
		run_frame(adc, -1, adc);
		check_results(adc);

		for (int f = 0; f < 8; f++) begin
			if (f == 0) begin
				for (int ch = 0; ch < `NLC_NUM_CH; ch++) begin
					load_random_channel(ch);
				end
			end else begin
				load_random_channel(f % `NLC_NUM_CH); // one channel changes per frame
			end
			adc = random_adc(15);
			for (int ch = 0; ch < `NLC_NUM_CH; ch++) begin
				for (int k = 0; k < `NLC_WORDS_PER_CH; k++) begin
					words[k*`NLC_WORD_W +: `NLC_WORD_W] = shadow[ch*`NLC_WORDS_PER_CH + k];
				end
				expected[ch*`NLC_SAMPLE_W +: `NLC_SAMPLE_W] =
					correct_sample(adc[ch*`NLC_SAMPLE_W +: `NLC_SAMPLE_W], words);
			end
			run_frame(adc, -1, adc);
			check_results(expected);
		end

		// Only coeff_0 left, far outside the sample range
		apply_reset();
		for (int ch = 0; ch < `NLC_NUM_CH; ch++) begin
			write_word(ch * `NLC_WORDS_PER_CH + 7, 32'h4000_0000);
		end
		run_frame(random_adc(`NLC_SAMPLE_W), -1, '0);
		check_results({`NLC_NUM_CH{21'h0F_FFFF}});
		for (int ch = 0; ch < `NLC_NUM_CH; ch++) begin
			write_word(ch * `NLC_WORDS_PER_CH + 7, 32'hC000_0000);
		end
		run_frame(random_adc(`NLC_SAMPLE_W), -1, '0);
		check_results({`NLC_NUM_CH{21'h10_0000}});

		apply_reset();
		load_identity();
		adc = random_adc(`NLC_SAMPLE_W);
		alt = random_adc(`NLC_SAMPLE_W);
		run_frame(adc, 10, alt);
		check_results(adc);
		repeat (20) begin
			@(negedge clk);
			check_value("srdyo", 0, srdyo);
			check_value("busy", 0, busy);
		end

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== nlc_controller.f ====
+incdir+common
+incdir+verif
common/nlc_pkg.sv
verilog/sample_capture.sv
verilog/coeff_table.sv
nlc_engine/nlc_sequencer.sv
nlc_engine/horner_datapath.sv
verilog/result_store.sv
verilog/nlc_controller.sv
verif/tb_nlc_controller.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_nlc_controller \
	-f nlc_controller.f \
	-o sim_nlc

./obj_dir/sim_nlc > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
